// ==== nx_pkg.sv ====
/*
 * nx_pkg
 * Shared types and sizes for the mesh routing node: directions, message
 * layout and inbound buffer depth
 */
`default_nettype none

package nx_pkg;

    // Mesh coordinate and payload widths
    localparam int NX_COORD_W   = 4;
    localparam int NX_PAYLOAD_W = 24;

    // Number of neighbour streams
    localparam int NX_DIR_COUNT = 4;

    // Inbound buffer sizing
    localparam int NX_FIFO_DEPTH = 2;
    localparam int NX_FIFO_PTR_W = $clog2(NX_FIFO_DEPTH);
    localparam int NX_FIFO_CNT_W = $clog2(NX_FIFO_DEPTH + 1);

    // Clockwise order, so +1 is the next direction in rotation
    typedef enum logic [1:0] {
        NX_DIR_NORTH = 2'd0,
        NX_DIR_EAST  = 2'd1,
        NX_DIR_SOUTH = 2'd2,
        NX_DIR_WEST  = 2'd3
    } nx_dir_t;

    // Single-flit message, 32 bits
    typedef struct packed {
        logic [NX_COORD_W-1:0]   row;
        logic [NX_COORD_W-1:0]   col;
        logic [NX_PAYLOAD_W-1:0] payload;
    } nx_msg_t;

    // Message tagged with the stream it arrived on
    typedef struct packed {
        nx_msg_t msg;
        nx_dir_t src;
    } nx_routed_t;

    // Buffer pointer and occupancy
    typedef logic [NX_FIFO_PTR_W-1:0] nx_fifo_ptr_t;
    typedef logic [NX_FIFO_CNT_W-1:0] nx_fifo_cnt_t;

endpackage : nx_pkg

`default_nettype wire

// ==== nx_stream_fifo.sv ====
/*
 * nx_stream_fifo
 * Small circular buffer for one inbound valid/ready stream, generic in its
 * payload type
 */
`timescale 1ns/100ps
`default_nettype none

module nx_stream_fifo #(
    parameter type payload_t = nx_pkg::nx_msg_t
) (
      input  logic     clk_i
    , input  logic     rst_i
    // Write side
    , input  payload_t push_data_i
    , input  logic     push_valid_i
    , output logic     push_ready_o
    // Read side
    , output payload_t pop_data_o
    , output logic     pop_valid_o
    , input  logic     pop_ready_i
);

    payload_t             mem_q [nx_pkg::NX_FIFO_DEPTH];
    nx_pkg::nx_fifo_ptr_t rd_ptr_q;
    nx_pkg::nx_fifo_ptr_t wr_ptr_q;
    nx_pkg::nx_fifo_cnt_t count_q;
    logic                 push;
    logic                 pop;

    function automatic nx_pkg::nx_fifo_ptr_t ptr_next(input nx_pkg::nx_fifo_ptr_t ptr);
        if (ptr == nx_pkg::nx_fifo_ptr_t'(nx_pkg::NX_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push_ready_o = (count_q != nx_pkg::nx_fifo_cnt_t'(nx_pkg::NX_FIFO_DEPTH));
    assign pop_valid_o  = (count_q != '0);
    assign pop_data_o   = mem_q[rd_ptr_q];

    assign push = push_valid_i && push_ready_o;
    assign pop  = pop_valid_o && pop_ready_i;

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_occupancy : assert property (@(posedge clk_i) disable iff (rst_i)
        count_q <= nx_pkg::nx_fifo_cnt_t'(nx_pkg::NX_FIFO_DEPTH));

    // Head entry must not move while the consumer stalls
    a_pop_stable : assert property (@(posedge clk_i) disable iff (rst_i)
        (pop_valid_o && !pop_ready_i) |=> (pop_valid_o && $stable(pop_data_o)));

endmodule : nx_stream_fifo

`default_nettype wire

// ==== nx_stream_arbiter.sv ====
/*
 * nx_stream_arbiter
 * Round-robin selection over the four inbound buffers into one registered
 * output slot tagged with the source direction
 */
`timescale 1ns/100ps
`default_nettype none

module nx_stream_arbiter (
      input  logic                              clk_i
    , input  logic                              rst_i
    // Inbound streams, indexed by direction
    , input  nx_pkg::nx_msg_t                   in_data_i [nx_pkg::NX_DIR_COUNT]
    , input  logic [nx_pkg::NX_DIR_COUNT-1:0]   in_valid_i
    , output logic [nx_pkg::NX_DIR_COUNT-1:0]   in_ready_o
    // Arbitrated stream
    , output nx_pkg::nx_routed_t                arb_data_o
    , output logic                              arb_valid_o
    , input  logic                              arb_ready_i
);

    nx_pkg::nx_dir_t    grant_q;
    nx_pkg::nx_dir_t    grant_d;
    nx_pkg::nx_routed_t arb_q;
    logic               arb_valid_q;
    logic               slot_free;
    logic               load;

    // Slot can take a new message when empty or emptying now
    assign slot_free = !arb_valid_q || arb_ready_i;
    assign load      = slot_free && in_valid_i[grant_q];

    assign arb_data_o  = arb_q;
    assign arb_valid_o = arb_valid_q;

    // Only the granted direction sees ready
    always_comb begin : p_ready
        in_ready_o          = '0;
        in_ready_o[grant_q] = slot_free;
    end

    // Next busy direction clockwise from the current grant
    always_comb begin : p_next_grant
        logic            found;
        nx_pkg::nx_dir_t cand;

        grant_d = grant_q;
        found   = 1'b0;
        for (int i = 1; i < nx_pkg::NX_DIR_COUNT; i++) begin
            cand = nx_pkg::nx_dir_t'(grant_q + 2'(i));
            if (!found && in_valid_i[cand]) begin
                grant_d = cand;
                found   = 1'b1;
            end
        end
    end

    // Grant moves only when the slot had room this cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            grant_q     <= nx_pkg::NX_DIR_NORTH;
            arb_valid_q <= 1'b0;
        end else if (slot_free) begin
            grant_q     <= grant_d;
            arb_valid_q <= in_valid_i[grant_q];
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            arb_q.msg <= in_data_i[grant_q];
            arb_q.src <= grant_q;
        end
    end

    a_one_ready : assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(in_ready_o));

    // Held slot keeps valid and contents until the router takes it
    a_arb_stable : assert property (@(posedge clk_i) disable iff (rst_i)
        (arb_valid_o && !arb_ready_i) |=> (arb_valid_o && $stable(arb_data_o)));

endmodule : nx_stream_arbiter

`default_nettype wire

// ==== nx_msg_router.sv ====
/*
 * nx_msg_router
 * Column-first routing of one message at a time into a registered output
 * toward a neighbour or the local port
 */
`timescale 1ns/100ps
`default_nettype none

module nx_msg_router #(
      parameter logic [nx_pkg::NX_COORD_W-1:0] NODE_ROW = '0
    , parameter logic [nx_pkg::NX_COORD_W-1:0] NODE_COL = '0
) (
      input  logic                              clk_i
    , input  logic                              rst_i
    // From the arbiter
    , input  nx_pkg::nx_routed_t                msg_i
    , input  logic                              msg_valid_i
    , output logic                              msg_ready_o
    // Neighbour streams, indexed by departure direction
    , output nx_pkg::nx_msg_t                   out_msg_o [nx_pkg::NX_DIR_COUNT]
    , output logic [nx_pkg::NX_DIR_COUNT-1:0]   out_valid_o
    , input  logic [nx_pkg::NX_DIR_COUNT-1:0]   out_ready_i
    // Local delivery
    , output nx_pkg::nx_routed_t                local_o
    , output logic                              local_valid_o
    , input  logic                              local_ready_i
);

    // One-hot destination, top bit is the local port
    logic [nx_pkg::NX_DIR_COUNT:0] route_sel;
    logic [nx_pkg::NX_DIR_COUNT:0] sel_q;
    nx_pkg::nx_routed_t            hold_q;
    logic                          drained;

    // Dimension order: columns first, then rows
    always_comb begin : p_route
        route_sel = '0;
        if (msg_i.msg.col > NODE_COL) begin
            route_sel[nx_pkg::NX_DIR_EAST] = 1'b1;
        end else if (msg_i.msg.col < NODE_COL) begin
            route_sel[nx_pkg::NX_DIR_WEST] = 1'b1;
        end else if (msg_i.msg.row > NODE_ROW) begin
            route_sel[nx_pkg::NX_DIR_SOUTH] = 1'b1;
        end else if (msg_i.msg.row < NODE_ROW) begin
            route_sel[nx_pkg::NX_DIR_NORTH] = 1'b1;
        end else begin
            route_sel[nx_pkg::NX_DIR_COUNT] = 1'b1;
        end
    end

    assign drained     = |(sel_q & {local_ready_i, out_ready_i});
    assign msg_ready_o = (sel_q == '0) || drained;

    assign out_valid_o   = sel_q[nx_pkg::NX_DIR_COUNT-1:0];
    assign local_valid_o = sel_q[nx_pkg::NX_DIR_COUNT];
    assign local_o       = hold_q;

    // Same held message on every neighbour, qualified by its valid
    always_comb begin : p_out_data
        for (int k = 0; k < nx_pkg::NX_DIR_COUNT; k++) begin
            out_msg_o[k] = hold_q.msg;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sel_q <= '0;
        end else if (msg_ready_o) begin
            sel_q <= msg_valid_i ? route_sel : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (msg_valid_i && msg_ready_o) begin
            hold_q <= msg_i;
        end
    end

    a_one_output : assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0({local_valid_o, out_valid_o}));

endmodule : nx_msg_router

`default_nettype wire

// ==== nx_node.sv ====
/*
 * nx_node
 * One mesh routing node: four inbound buffers, a round-robin arbiter and
 * a column-first router
 */
`timescale 1ns/100ps
`default_nettype none

module nx_node #(
      parameter logic [nx_pkg::NX_COORD_W-1:0] NODE_ROW = '0
    , parameter logic [nx_pkg::NX_COORD_W-1:0] NODE_COL = '0
) (
      input  logic                              clk_i
    , input  logic                              rst_i
    // Inbound neighbour streams
    , input  nx_pkg::nx_msg_t                   in_msg_i [nx_pkg::NX_DIR_COUNT]
    , input  logic [nx_pkg::NX_DIR_COUNT-1:0]   in_valid_i
    , output logic [nx_pkg::NX_DIR_COUNT-1:0]   in_ready_o
    // Outbound neighbour streams
    , output nx_pkg::nx_msg_t                   out_msg_o [nx_pkg::NX_DIR_COUNT]
    , output logic [nx_pkg::NX_DIR_COUNT-1:0]   out_valid_o
    , input  logic [nx_pkg::NX_DIR_COUNT-1:0]   out_ready_i
    // Local delivery
    , output nx_pkg::nx_routed_t                local_o
    , output logic                              local_valid_o
    , input  logic                              local_ready_i
);

    // Buffer outputs toward the arbiter
    nx_pkg::nx_msg_t                 buf_data [nx_pkg::NX_DIR_COUNT];
    logic [nx_pkg::NX_DIR_COUNT-1:0] buf_valid;
    logic [nx_pkg::NX_DIR_COUNT-1:0] buf_ready;

    // Arbiter to router
    nx_pkg::nx_routed_t arb_data;
    logic               arb_valid;
    logic               arb_ready;

    for (genvar k = 0; k < nx_pkg::NX_DIR_COUNT; k++) begin : g_inbound
        nx_stream_fifo #(
            .payload_t    ( nx_pkg::nx_msg_t )
        ) u_fifo (
              .clk_i        ( clk_i          )
            , .rst_i        ( rst_i          )
            , .push_data_i  ( in_msg_i[k]    )
            , .push_valid_i ( in_valid_i[k]  )
            , .push_ready_o ( in_ready_o[k]  )
            , .pop_data_o   ( buf_data[k]    )
            , .pop_valid_o  ( buf_valid[k]   )
            , .pop_ready_i  ( buf_ready[k]   )
        );
    end

    nx_stream_arbiter u_arbiter (
          .clk_i       ( clk_i     )
        , .rst_i       ( rst_i     )
        , .in_data_i   ( buf_data  )
        , .in_valid_i  ( buf_valid )
        , .in_ready_o  ( buf_ready )
        , .arb_data_o  ( arb_data  )
        , .arb_valid_o ( arb_valid )
        , .arb_ready_i ( arb_ready )
    );

    nx_msg_router #(
          .NODE_ROW ( NODE_ROW )
        , .NODE_COL ( NODE_COL )
    ) u_router (
          .clk_i         ( clk_i         )
        , .rst_i         ( rst_i         )
        , .msg_i         ( arb_data      )
        , .msg_valid_i   ( arb_valid     )
        , .msg_ready_o   ( arb_ready     )
        , .out_msg_o     ( out_msg_o     )
        , .out_valid_o   ( out_valid_o   )
        , .out_ready_i   ( out_ready_i   )
        , .local_o       ( local_o       )
        , .local_valid_o ( local_valid_o )
        , .local_ready_i ( local_ready_i )
    );

endmodule : nx_node

`default_nettype wire

// ==== tb_clk_gen.sv ====
/*
 * tb_clk_gen
 * Free-running 10 ns clock and a synchronous reset held for four cycles
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
      output logic clk_o
    , output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

    // Released just after the fourth rising edge
    initial begin
        rst_o = 1'b1;
        repeat (4) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule : tb_clk_gen

`default_nettype wire

// ==== nx_node_tb.sv ====
/*
 * nx_node_tb
 * Testbench for the mesh routing node: random traffic from four neighbours,
 * per-pair reference queues, fairness and back-pressure checks
 */
`timescale 1ns/100ps
`default_nettype none

module nx_node_tb;

    typedef logic [nx_pkg::NX_COORD_W-1:0] coord_t;

    localparam coord_t NODE_ROW       = 4'd2;
    localparam coord_t NODE_COL       = 4'd2;
    localparam int     NUM_PORTS      = nx_pkg::NX_DIR_COUNT + 1;
    localparam int     LOCAL_PORT     = nx_pkg::NX_DIR_COUNT;
    localparam int     NUM_PAIRS      = nx_pkg::NX_DIR_COUNT * NUM_PORTS;
    localparam int     ROUTE_PER_SRC  = 40;
    localparam int     FAIR_PER_SRC   = 10;
    localparam int     BP_PER_SRC     = 25;
    localparam int     TOTAL_MSGS     = 4 * (ROUTE_PER_SRC + FAIR_PER_SRC + BP_PER_SRC);
    // About twenty cycles per message, back-pressure included
    localparam int     TIMEOUT_CYCLES = 20 * TOTAL_MSGS;
    localparam int     RAND_SEED      = 32'h17d4_f581;

    logic clk;
    logic rst;

    nx_pkg::nx_msg_t                 in_msg [nx_pkg::NX_DIR_COUNT];
    logic [nx_pkg::NX_DIR_COUNT-1:0] in_valid;
    logic [nx_pkg::NX_DIR_COUNT-1:0] in_ready;
    nx_pkg::nx_msg_t                 out_msg [nx_pkg::NX_DIR_COUNT];
    logic [nx_pkg::NX_DIR_COUNT-1:0] out_valid;
    logic [nx_pkg::NX_DIR_COUNT-1:0] out_ready;
    nx_pkg::nx_routed_t              local_msg;
    logic                            local_valid;
    logic                            local_ready;

    // Expected messages, indexed by source * NUM_PORTS + destination
    nx_pkg::nx_msg_t exp_q [NUM_PAIRS][$];

    string           test_name;
    int              cycle_cnt;
    int              msg_seq;
    int              sent_total;
    int              recv_total;
    int              stall_cycles;
    int              fair_seen;
    int              route_hits [NUM_PORTS];
    bit              fair_mode;
    bit              bp_mode;
    nx_pkg::nx_dir_t last_src;

    tb_clk_gen u_clk_gen (
          .clk_o ( clk )
        , .rst_o ( rst )
    );

    nx_node #(
          .NODE_ROW ( NODE_ROW )
        , .NODE_COL ( NODE_COL )
    ) dut0 (
          .clk_i         ( clk         )
        , .rst_i         ( rst         )
        , .in_msg_i      ( in_msg      )
        , .in_valid_i    ( in_valid    )
        , .in_ready_o    ( in_ready    )
        , .out_msg_o     ( out_msg     )
        , .out_valid_o   ( out_valid   )
        , .out_ready_i   ( out_ready   )
        , .local_o       ( local_msg   )
        , .local_valid_o ( local_valid )
        , .local_ready_i ( local_ready )
    );

    task automatic fail_value(input string what, input logic [63:0] want,
                              input logic [63:0] got);
        $display("Fail %s %s: expected %0h actual %0h", test_name, what, want, got);
        $display("test failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic fail_other(input string what);
        $display("Error in %s: %s", test_name, what);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    // Column first, then row; index 4 is the local port
    function automatic int expected_port(input nx_pkg::nx_msg_t m);
        int dcol;
        int drow;
        dcol = int'(m.col) - int'(NODE_COL);
        drow = int'(m.row) - int'(NODE_ROW);
        if (dcol > 0) begin
            return int'(nx_pkg::NX_DIR_EAST);
        end
        if (dcol < 0) begin
            return int'(nx_pkg::NX_DIR_WEST);
        end
        if (drow > 0) begin
            return int'(nx_pkg::NX_DIR_SOUTH);
        end
        if (drow < 0) begin
            return int'(nx_pkg::NX_DIR_NORTH);
        end
        return LOCAL_PORT;
    endfunction

    // Source direction rides in the top two payload bits
    function automatic int tag_source(input nx_pkg::nx_msg_t m);
        return int'(m.payload[nx_pkg::NX_PAYLOAD_W-1 -: 2]);
    endfunction

    function automatic nx_pkg::nx_msg_t make_msg(input int src, input bit to_local,
                                                 input int seq);
        nx_pkg::nx_msg_t m;
        if (to_local) begin
            m.row = NODE_ROW;
            m.col = NODE_COL;
        end else begin
            m.row = coord_t'($urandom % 5);
            m.col = coord_t'($urandom % 5);
        end
        m.payload = {2'(src), 10'(seq), 12'($urandom)};
        return m;
    endfunction

    function automatic int pending_count();
        int total;
        total = 0;
        for (int i = 0; i < NUM_PAIRS; i++) begin
            total += exp_q[i].size();
        end
        return total;
    endfunction

    task automatic record_sent(input int src, input nx_pkg::nx_msg_t m);
        int port;
        port = expected_port(m);
        exp_q[src * NUM_PORTS + port].push_back(m);
        route_hits[port]++;
        sent_total++;
    endtask

    task automatic check_delivery(input int port, input nx_pkg::nx_msg_t got, input int src);
        int              idx;
        nx_pkg::nx_msg_t want;
        idx = src * NUM_PORTS + port;
        assert (exp_q[idx].size() > 0)
            else fail_other($sformatf("unexpected message %h on port %0d", got, port));
        want = exp_q[idx].pop_front();
        assert (got == want)
            else fail_value($sformatf("port %0d from source %0d", port, src),
                            64'(want), 64'(got));
        recv_total++;
    endtask

    task automatic check_rotation(input nx_pkg::nx_dir_t src);
        nx_pkg::nx_dir_t want;
        want = nx_pkg::nx_dir_t'(last_src + 2'd1);
        if (fair_seen > 0) begin
            assert (src == want)
                else fail_value("local delivery order", 64'(want), 64'(src));
        end
        last_src = src;
        fair_seen++;
    endtask

    // Holds valid and data until the node takes the message
    task automatic send_stream(input int src, input int count, input bit to_local,
                               input int gap_pct);
        int              sent;
        nx_pkg::nx_msg_t m;
        sent = 0;
        while (sent < count) begin
            if (gap_pct > 0 && int'($urandom % 100) < gap_pct) begin
                in_valid[src] = 1'b0;
                @(posedge clk);
                #1;
            end else begin
                m = make_msg(src, to_local, msg_seq);
                msg_seq++;
                in_msg[src]   = m;
                in_valid[src] = 1'b1;
                // Ready is registered, so it is settled mid-cycle
                while (!in_ready[src]) begin
                    @(posedge clk);
                    #1;
                end
                @(posedge clk);
                record_sent(src, m);
                #1;
                sent++;
            end
        end
        in_valid[src] = 1'b0;
    endtask

    task automatic shake_readies();
        while (bp_mode) begin
            out_ready   = 4'($urandom);
            local_ready = 1'($urandom);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drained();
        while (pending_count() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Scoreboard on every outbound transfer
    always @(posedge clk) begin
        if (!rst) begin
            for (int k = 0; k < nx_pkg::NX_DIR_COUNT; k++) begin
                if (out_valid[k] && out_ready[k]) begin
                    check_delivery(k, out_msg[k], tag_source(out_msg[k]));
                end
            end
            if (local_valid && local_ready) begin
                assert (int'(local_msg.src) == tag_source(local_msg.msg))
                    else fail_value("local source direction",
                                    64'(tag_source(local_msg.msg)), 64'(local_msg.src));
                check_delivery(LOCAL_PORT, local_msg.msg, int'(local_msg.src));
                if (fair_mode) begin
                    check_rotation(local_msg.src);
                end
            end
            if (bp_mode && in_ready != '1) begin
                stall_cycles++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_other($sformatf("no verdict after %0d cycles", cycle_cnt));
        end
    end

    for (genvar k = 0; k < nx_pkg::NX_DIR_COUNT; k++) begin : g_out_hold
        a_out_hold : assert property (@(posedge clk) disable iff (rst)
            (out_valid[k] && !out_ready[k]) |=> (out_valid[k] && $stable(out_msg[k])))
            else fail_other($sformatf("neighbour output %0d changed while stalled", k));
    end

    a_local_hold : assert property (@(posedge clk) disable iff (rst)
        (local_valid && !local_ready) |=> (local_valid && $stable(local_msg)))
        else fail_other("local output changed while stalled");

    initial begin
        void'($urandom(RAND_SEED));
        for (int k = 0; k < nx_pkg::NX_DIR_COUNT; k++) begin
            in_msg[k] = '0;
        end
        in_valid    = '0;
        out_ready   = '1;
        local_ready = 1'b1;
        fair_mode   = 1'b0;
        bp_mode     = 1'b0;
        last_src    = nx_pkg::NX_DIR_NORTH;
        test_name   = "reset";

        @(negedge rst);
        assert (out_valid == '0 && !local_valid)
            else fail_value("output valids", 64'(0), 64'({local_valid, out_valid}));
        assert (in_ready == '1)
            else fail_value("inbound readies", 64'(4'hf), 64'(in_ready));

        test_name = "routing";
        fork
            send_stream(0, ROUTE_PER_SRC, 1'b0, 30);
            send_stream(1, ROUTE_PER_SRC, 1'b0, 30);
            send_stream(2, ROUTE_PER_SRC, 1'b0, 30);
            send_stream(3, ROUTE_PER_SRC, 1'b0, 30);
        join
        wait_drained();
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (route_hits[p] > 0)
                else fail_other($sformatf("no message was routed to port %0d", p));
        end

        // All sources backlogged toward the local port
        test_name = "fairness";
        fair_seen = 0;
        fair_mode = 1'b1;
        fork
            send_stream(0, FAIR_PER_SRC, 1'b1, 0);
            send_stream(1, FAIR_PER_SRC, 1'b1, 0);
            send_stream(2, FAIR_PER_SRC, 1'b1, 0);
            send_stream(3, FAIR_PER_SRC, 1'b1, 0);
        join
        wait_drained();
        fair_mode = 1'b0;
        assert (fair_seen == 4 * FAIR_PER_SRC)
            else fail_value("local deliveries", 64'(4 * FAIR_PER_SRC), 64'(fair_seen));

        test_name = "backpressure";
        bp_mode   = 1'b1;
        fork
            begin
                fork
                    send_stream(0, BP_PER_SRC, 1'b0, 0);
                    send_stream(1, BP_PER_SRC, 1'b0, 0);
                    send_stream(2, BP_PER_SRC, 1'b0, 0);
                    send_stream(3, BP_PER_SRC, 1'b0, 0);
                join
                bp_mode = 1'b0;
            end
            shake_readies();
        join
        out_ready   = '1;
        local_ready = 1'b1;
        wait_drained();
        assert (stall_cycles > 0)
            else fail_other("inbound ready never fell under back-pressure");

        test_name = "final";
        if (sent_total == TOTAL_MSGS && recv_total == TOTAL_MSGS && pending_count() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            fail_value("delivered messages", 64'(TOTAL_MSGS), 64'(recv_total));
        end
    end

endmodule : nx_node_tb

`default_nettype wire

// ==== all.f ====
nx_pkg.sv
nx_stream_fifo.sv
nx_stream_arbiter.sv
nx_msg_router.sv
nx_node.sv
tb_clk_gen.sv
nx_node_tb.sv

// ==== Makefile ====
# Verilator flow for the mesh routing node

TB_TOP := nx_node_tb

.PHONY: all lint sim clean

all: sim

# Lint the synthesizable design only
lint:
	verilator --lint-only -Wall --timing --top-module nx_node -f all.f

# Build and run the testbench; a $fatal gives a nonzero exit status
sim:
	verilator --binary --timing --assert -j 0 \
		--top-module $(TB_TOP) -f all.f -o $(TB_TOP)_sim
	./obj_dir/$(TB_TOP)_sim

clean:
	rm -rf obj_dir
